// File: axi_id_serialize.f
+incdir+logic
logic/ids_pkg.sv
logic/ids_ar_demux.sv
logic/ids_serializer.sv
logic/ids_ar_mux.sv
logic/axi_id_serialize.sv
sim/tb_clk_gen.sv
sim/tb_axi_id_serialize.sv

// File: logic/axi_id_serialize.sv
// **********************************************************************
// Read-channel AXI ID serializer: demux, per-ID slots, AR mux
// **********************************************************************

`timescale 1ns/1ps

`include "ids_defines.svh"

module axi_id_serialize (
  input  logic             clk_i,
  input  logic             arst_n_i,
  // Slave port, wide ID
  input  logic             slv_ar_valid_i,
  input  ids_pkg::slv_ar_t slv_ar_i,
  output logic             slv_ar_ready_o,
  output logic             slv_r_valid_o,
  output ids_pkg::slv_r_t  slv_r_o,
  input  logic             slv_r_ready_i,
  // Master port, narrow ID
  output logic             mst_ar_valid_o,
  output ids_pkg::mst_ar_t mst_ar_o,
  input  logic             mst_ar_ready_i,
  input  logic             mst_r_valid_i,
  input  ids_pkg::mst_r_t  mst_r_i,
  output logic             mst_r_ready_o
);

  // Demux side of the slots
  logic [`IDS_NUM_SLOTS-1:0]              dmx_ar_valid;
  ids_pkg::slv_ar_t [`IDS_NUM_SLOTS-1:0]  dmx_ar;
  logic [`IDS_NUM_SLOTS-1:0]              dmx_ar_ready;
  logic [`IDS_NUM_SLOTS-1:0]              ser_r_valid;
  ids_pkg::slv_r_t [`IDS_NUM_SLOTS-1:0]   ser_r;
  logic [`IDS_NUM_SLOTS-1:0]              ser_r_ready;
  // Mux side of the slots
  logic [`IDS_NUM_SLOTS-1:0]              ser_ar_valid;
  ids_pkg::mst_ar_t [`IDS_NUM_SLOTS-1:0]  ser_ar;
  logic [`IDS_NUM_SLOTS-1:0]              ser_ar_ready;
  logic [`IDS_NUM_SLOTS-1:0]              mux_r_valid;
  ids_pkg::mst_r_t [`IDS_NUM_SLOTS-1:0]   mux_r;
  logic [`IDS_NUM_SLOTS-1:0]              mux_r_ready;

  ids_ar_demux i_demux (
    .clk_i           ( clk_i          ),
    .arst_n_i        ( arst_n_i       ),
    .slv_ar_valid_i  ( slv_ar_valid_i ),
    .slv_ar_i        ( slv_ar_i       ),
    .slv_ar_ready_o  ( slv_ar_ready_o ),
    .slot_ar_valid_o ( dmx_ar_valid   ),
    .slot_ar_o       ( dmx_ar         ),
    .slot_ar_ready_i ( dmx_ar_ready   ),
    .slot_r_valid_i  ( ser_r_valid    ),
    .slot_r_i        ( ser_r          ),
    .slot_r_ready_o  ( ser_r_ready    ),
    .slv_r_valid_o   ( slv_r_valid_o  ),
    .slv_r_o         ( slv_r_o        ),
    .slv_r_ready_i   ( slv_r_ready_i  )
  );

  // One slot per master ID
  for (genvar i = 0; i < `IDS_NUM_SLOTS; i++) begin : gen_slots
    ids_serializer #(
      .SLOT ( i )
    ) i_serializer (
      .clk_i          ( clk_i           ),
      .arst_n_i       ( arst_n_i        ),
      .in_ar_valid_i  ( dmx_ar_valid[i] ),
      .in_ar_i        ( dmx_ar[i]       ),
      .in_ar_ready_o  ( dmx_ar_ready[i] ),
      .out_ar_valid_o ( ser_ar_valid[i] ),
      .out_ar_o       ( ser_ar[i]       ),
      .out_ar_ready_i ( ser_ar_ready[i] ),
      .in_r_valid_i   ( mux_r_valid[i]  ),
      .in_r_i         ( mux_r[i]        ),
      .in_r_ready_o   ( mux_r_ready[i]  ),
      .out_r_valid_o  ( ser_r_valid[i]  ),
      .out_r_o        ( ser_r[i]        ),
      .out_r_ready_i  ( ser_r_ready[i]  )
    );
  end

  ids_ar_mux i_mux (
    .clk_i           ( clk_i          ),
    .arst_n_i        ( arst_n_i       ),
    .slot_ar_valid_i ( ser_ar_valid   ),
    .slot_ar_i       ( ser_ar         ),
    .slot_ar_ready_o ( ser_ar_ready   ),
    .mst_ar_valid_o  ( mst_ar_valid_o ),
    .mst_ar_o        ( mst_ar_o       ),
    .mst_ar_ready_i  ( mst_ar_ready_i ),
    .mst_r_valid_i   ( mst_r_valid_i  ),
    .mst_r_i         ( mst_r_i        ),
    .mst_r_ready_o   ( mst_r_ready_o  ),
    .slot_r_valid_o  ( mux_r_valid    ),
    .slot_r_o        ( mux_r          ),
    .slot_r_ready_i  ( mux_r_ready    )
  );

endmodule

// File: logic/ids_ar_demux.sv
// **********************************************************************
// Slave AR steering onto the slots and merge of slot R beats
// **********************************************************************

`timescale 1ns/1ps

`include "ids_defines.svh"

module ids_ar_demux (
  // Only used by the R-side check
  input  logic                                       clk_i,
  input  logic                                       arst_n_i,
  // Slave port AR
  input  logic                                       slv_ar_valid_i,
  input  ids_pkg::slv_ar_t                           slv_ar_i,
  output logic                                       slv_ar_ready_o,
  // AR towards the slots
  output logic [`IDS_NUM_SLOTS-1:0]                  slot_ar_valid_o,
  output ids_pkg::slv_ar_t [`IDS_NUM_SLOTS-1:0]      slot_ar_o,
  input  logic [`IDS_NUM_SLOTS-1:0]                  slot_ar_ready_i,
  // R from the slots
  input  logic [`IDS_NUM_SLOTS-1:0]                  slot_r_valid_i,
  input  ids_pkg::slv_r_t [`IDS_NUM_SLOTS-1:0]       slot_r_i,
  output logic [`IDS_NUM_SLOTS-1:0]                  slot_r_ready_o,
  // Slave port R
  output logic                                       slv_r_valid_o,
  output ids_pkg::slv_r_t                            slv_r_o,
  input  logic                                       slv_r_ready_i
);

  // One extra bit so the offset never wraps before the modulo
  logic [`IDS_SLV_ID_W:0] id_sum;
  ids_pkg::slot_idx_t     ar_sel;

  // Default mapping rule, master ID = (slave ID + offset) mod slots
  assign id_sum = {1'b0, slv_ar_i.id} + (`IDS_SLV_ID_W+1)'(`IDS_ID_BASE_OFFSET);
  assign ar_sel = ids_pkg::slot_idx_t'(id_sum % `IDS_NUM_SLOTS);

  // Payload goes to every slot, only the selected one sees valid
  always_comb begin
    for (int i = 0; i < `IDS_NUM_SLOTS; i++) begin
      slot_ar_o[i]       = slv_ar_i;
      slot_ar_valid_o[i] = slv_ar_valid_i && (ar_sel == ids_pkg::slot_idx_t'(i));
    end
  end

  // Ready comes back from the addressed slot only
  assign slv_ar_ready_o = slot_ar_ready_i[ar_sel];

  // R enters from a single master channel, so at most one slot is valid
  always_comb begin
    slv_r_valid_o = 1'b0;
    slv_r_o       = '0;
    for (int i = 0; i < `IDS_NUM_SLOTS; i++) begin
      if (slot_r_valid_i[i]) begin
        slv_r_valid_o = 1'b1;
        slv_r_o       = slot_r_i[i];
      end
    end
  end

  // Harmless to all slots since only the valid one takes a beat
  assign slot_r_ready_o = {`IDS_NUM_SLOTS{slv_r_ready_i}};

  // Mux steers each master R beat to exactly one slot
  a_one_slot_r: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    $onehot0(slot_r_valid_i)
  );

endmodule

// File: logic/ids_ar_mux.sv
// **********************************************************************
// Round-robin AR arbitration into a master AR register, R routing by ID
// **********************************************************************

`timescale 1ns/1ps

`include "ids_defines.svh"

module ids_ar_mux (
  input  logic                                   clk_i,
  input  logic                                   arst_n_i,
  // AR from the slots
  input  logic [`IDS_NUM_SLOTS-1:0]              slot_ar_valid_i,
  input  ids_pkg::mst_ar_t [`IDS_NUM_SLOTS-1:0]  slot_ar_i,
  output logic [`IDS_NUM_SLOTS-1:0]              slot_ar_ready_o,
  // Master port AR
  output logic                                   mst_ar_valid_o,
  output ids_pkg::mst_ar_t                       mst_ar_o,
  input  logic                                   mst_ar_ready_i,
  // Master port R
  input  logic                                   mst_r_valid_i,
  input  ids_pkg::mst_r_t                        mst_r_i,
  output logic                                   mst_r_ready_o,
  // R towards the slots
  output logic [`IDS_NUM_SLOTS-1:0]              slot_r_valid_o,
  output ids_pkg::mst_r_t [`IDS_NUM_SLOTS-1:0]   slot_r_o,
  input  logic [`IDS_NUM_SLOTS-1:0]              slot_r_ready_i
);

  ids_pkg::slot_idx_t rr_ptr_q;
  ids_pkg::slot_idx_t gnt_idx;
  logic               gnt_found;
  logic               load_en;
  logic               ar_valid_q;
  ids_pkg::mst_ar_t   ar_q;

  // Register loads when empty or drained this cycle
  assign load_en = !ar_valid_q || mst_ar_ready_i;

  // First requester at or after the pointer wins
  always_comb begin
    int unsigned idx;
    gnt_found = 1'b0;
    gnt_idx   = rr_ptr_q;
    for (int k = 0; k < `IDS_NUM_SLOTS; k++) begin
      idx = (int'(rr_ptr_q) + k) % `IDS_NUM_SLOTS;
      if (!gnt_found && slot_ar_valid_i[idx]) begin
        gnt_found = 1'b1;
        gnt_idx   = ids_pkg::slot_idx_t'(idx);
      end
    end
  end

  always_comb begin
    for (int i = 0; i < `IDS_NUM_SLOTS; i++) begin
      slot_ar_ready_o[i] = load_en && gnt_found && (gnt_idx == ids_pkg::slot_idx_t'(i));
    end
  end

  // Valid and pointer are control state
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ar_valid_q <= 1'b0;
      rr_ptr_q   <= '0;
    end else if (load_en) begin
      ar_valid_q <= gnt_found;
      if (gnt_found) begin
        // Move past the winner for fairness
        rr_ptr_q <= ids_pkg::slot_idx_t'((int'(gnt_idx) + 1) % `IDS_NUM_SLOTS);
      end
    end
  end

  // Slot already carries its index as the ID
  always_ff @(posedge clk_i) begin
    if (load_en && gnt_found) begin
      ar_q <= slot_ar_i[gnt_idx];
    end
  end

  assign mst_ar_valid_o = ar_valid_q;
  assign mst_ar_o       = ar_q;

  // R beat goes to the slot named by its ID
  always_comb begin
    for (int i = 0; i < `IDS_NUM_SLOTS; i++) begin
      slot_r_o[i]       = mst_r_i;
      slot_r_valid_o[i] = mst_r_valid_i && (mst_r_i.id == ids_pkg::slot_idx_t'(i));
    end
  end

  assign mst_r_ready_o = slot_r_ready_i[mst_r_i.id];

  // Master sees a stable AR until it takes it
  a_ar_stable: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    (mst_ar_valid_o && !mst_ar_ready_i) |=> (mst_ar_valid_o && $stable(mst_ar_o))
  );

endmodule

// File: logic/ids_defines.svh
// **********************************************************************
// Width, count and offset macros of the AXI read ID serializer
// **********************************************************************

`ifndef IDS_DEFINES_SVH
`define IDS_DEFINES_SVH

// ID widths at the slave and master ports
`define IDS_SLV_ID_W 4
`define IDS_MST_ID_W 2

// One serializer slot per master ID
`define IDS_NUM_SLOTS 4

// Payload widths
`define IDS_ADDR_W 32
`define IDS_DATA_W 32
`define IDS_LEN_W 8

// Outstanding bursts a slot may hold for its owner
`define IDS_MAX_TXNS_PER_ID 4
// Added to the slave ID before the modulo
`define IDS_ID_BASE_OFFSET 1

`endif

// File: logic/ids_pkg.sv
// **********************************************************************
// AR and R channel structs, slot index type, response and slot enums
// **********************************************************************

`include "ids_defines.svh"

package ids_pkg;

  // Index of a serializer slot, equal to the master ID it issues
  typedef logic [$clog2(`IDS_NUM_SLOTS)-1:0] slot_idx_t;

  // AXI response codes
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    EXOKAY = 2'b01,
    SLVERR = 2'b10,
    DECERR = 2'b11
  } resp_e;

  // Ownership state of one slot
  typedef enum logic [1:0] {
    SLOT_FREE,
    SLOT_OWNED,
    SLOT_FULL
  } slot_state_e;

  // AR at the slave port, wide ID
  typedef struct packed {
    logic [`IDS_SLV_ID_W-1:0] id;
    logic [`IDS_ADDR_W-1:0]   addr;
    logic [`IDS_LEN_W-1:0]    len;
  } slv_ar_t;

  // AR at the master port, narrow ID
  typedef struct packed {
    logic [`IDS_MST_ID_W-1:0] id;
    logic [`IDS_ADDR_W-1:0]   addr;
    logic [`IDS_LEN_W-1:0]    len;
  } mst_ar_t;

  // R beat at the slave port
  typedef struct packed {
    logic [`IDS_SLV_ID_W-1:0] id;
    logic [`IDS_DATA_W-1:0]   data;
    resp_e                    resp;
    logic                     last;
  } slv_r_t;

  // R beat at the master port
  typedef struct packed {
    logic [`IDS_MST_ID_W-1:0] id;
    logic [`IDS_DATA_W-1:0]   data;
    resp_e                    resp;
    logic                     last;
  } mst_r_t;

endpackage

// File: logic/ids_serializer.sv
// **********************************************************************
// One serializer slot: owner tracking, in-flight count, ID swap
// **********************************************************************

`timescale 1ns/1ps

`include "ids_defines.svh"

module ids_serializer #(
  parameter int unsigned SLOT = 0
) (
  input  logic             clk_i,
  input  logic             arst_n_i,
  // AR from the demux
  input  logic             in_ar_valid_i,
  input  ids_pkg::slv_ar_t in_ar_i,
  output logic             in_ar_ready_o,
  // AR towards the mux
  output logic             out_ar_valid_o,
  output ids_pkg::mst_ar_t out_ar_o,
  input  logic             out_ar_ready_i,
  // R from the mux
  input  logic             in_r_valid_i,
  input  ids_pkg::mst_r_t  in_r_i,
  output logic             in_r_ready_o,
  // R towards the demux
  output logic             out_r_valid_o,
  output ids_pkg::slv_r_t  out_r_o,
  input  logic             out_r_ready_i
);

  // Fixed master ID issued by this slot
  localparam logic [`IDS_MST_ID_W-1:0] SLOT_ID = SLOT[`IDS_MST_ID_W-1:0];
  // Counter holds 0 up to the limit inclusive
  localparam int unsigned CNT_W = $clog2(`IDS_MAX_TXNS_PER_ID + 1);

  ids_pkg::slot_state_e     state_q, state_d;
  logic [CNT_W-1:0]         cnt_q, cnt_d;
  logic [`IDS_SLV_ID_W-1:0] owner_q;
  logic                     admit;
  logic                     ar_hs;
  logic                     r_done;

  // Free slot takes any ID; owned slot only its owner until full
  assign admit = (state_q == ids_pkg::SLOT_FREE) ||
                 ((state_q == ids_pkg::SLOT_OWNED) && (in_ar_i.id == owner_q));

  assign out_ar_valid_o = in_ar_valid_i && admit;
  assign in_ar_ready_o  = out_ar_ready_i && admit;
  assign out_ar_o       = '{id: SLOT_ID, addr: in_ar_i.addr, len: in_ar_i.len};

  assign ar_hs  = in_ar_valid_i && in_ar_ready_o;
  // A burst retires on its last beat
  assign r_done = in_r_valid_i && out_r_ready_i && in_r_i.last;

  // R passes straight through with the owner ID put back
  assign out_r_valid_o = in_r_valid_i;
  assign in_r_ready_o  = out_r_ready_i;
  assign out_r_o       = '{id: owner_q, data: in_r_i.data, resp: in_r_i.resp,
                           last: in_r_i.last};

  always_comb begin
    cnt_d = cnt_q;
    if (ar_hs && !r_done) begin
      cnt_d = cnt_q + CNT_W'(1);
    end else if (r_done && !ar_hs) begin
      cnt_d = cnt_q - CNT_W'(1);
    end
    // State follows the next count
    if (cnt_d == '0) begin
      state_d = ids_pkg::SLOT_FREE;
    end else if (cnt_d == CNT_W'(`IDS_MAX_TXNS_PER_ID)) begin
      state_d = ids_pkg::SLOT_FULL;
    end else begin
      state_d = ids_pkg::SLOT_OWNED;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= ids_pkg::SLOT_FREE;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
    end
  end

  // Owner only matters while count is nonzero
  always_ff @(posedge clk_i) begin
    if (ar_hs) begin
      owner_q <= in_ar_i.id;
    end
  end

  // Master must not answer a burst this slot never issued
  a_no_r_idle: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    in_r_valid_i |-> (cnt_q != '0)
  );

  a_cnt_limit: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    cnt_q <= CNT_W'(`IDS_MAX_TXNS_PER_ID)
  );

endmodule

// File: sim/ids_cases.txt
// One read per line: slave ID _ address _ burst length, all hex
// Master ID is (slave ID + 1) mod 4
// Same ID six times, fills slot 2
5_00001000_07
5_00001100_07
5_00001200_07
5_00001300_07
5_00001400_07
5_00001500_03
// Slave IDs 3, 7, b, f share master ID 0
3_00002000_02
7_00002100_04
3_00002200_00
b_00002300_01
f_00002400_06
7_00002500_03
// One of each master ID
0_00003000_03
4_00003100_02
1_00003200_05
2_00003300_01
6_00003400_07
a_00003500_00
e_00003600_02
8_00003700_03
c_00003800_01
9_00003900_04
d_00003a00_02
// Runs and switches on master ID 3
2_00004000_05
2_00004100_00
2_00004200_03
6_00004300_01
a_00004400_07
e_00004500_02
// Mixed traffic
0_00005000_00
1_00005100_06
3_00005200_01
4_00005300_07
5_00005400_02
8_00005500_04
9_00005600_03
c_00005700_05
d_00005800_00
f_00005900_07
b_00005a00_02
7_00005b00_01

// File: sim/tb_axi_id_serialize.sv
// **********************************************************************
// AXI read ID serializer testbench: case stimulus, slave memory model,
// scoreboard with serialization and in-flight checks, timeout
// **********************************************************************

`timescale 1ns/1ps

`include "ids_defines.svh"

module tb_axi_id_serialize;

  localparam int MAX_CASES = 64;
  localparam int NUM_SIDS  = 1 << `IDS_SLV_ID_W;
  localparam int CASE_W    = `IDS_SLV_ID_W + `IDS_ADDR_W + `IDS_LEN_W;

  logic             clk;
  logic             arst_n;
  logic             slv_ar_valid;
  ids_pkg::slv_ar_t slv_ar;
  logic             slv_ar_ready;
  logic             slv_r_valid;
  ids_pkg::slv_r_t  slv_r;
  logic             slv_r_ready;
  logic             mst_ar_valid;
  ids_pkg::mst_ar_t mst_ar;
  logic             mst_ar_ready;
  logic             mst_r_valid;
  ids_pkg::mst_r_t  mst_r;
  logic             mst_r_ready;

  // Cases as {slave ID, address, length}
  logic [CASE_W-1:0] case_mem [MAX_CASES];
  int          n_cases;
  int          case_idx;
  int          max_len;
  int          limit_cycles;
  int          cycle_cnt;
  int          check_cnt;
  int          error_cnt;
  int          done_cnt;
  logic        run_en;
  logic [31:0] lfsr_q;

  // Accepted at slave port, not yet seen at master port
  ids_pkg::slv_ar_t         pend_q [$];
  // Bursts still owed R beats
  ids_pkg::slv_ar_t         exp_q [$];
  int                       sid_beat [NUM_SIDS];
  int                       in_flight [`IDS_NUM_SLOTS];
  logic [`IDS_SLV_ID_W-1:0] owner_sid [`IDS_NUM_SLOTS];

  // Slave memory model state
  ids_pkg::mst_ar_t mem_q [$];
  int               mem_beat [`IDS_NUM_SLOTS];

  // Handshakes seen at the last rising edge
  logic             slv_ar_hs_q;
  logic             mst_ar_hs_q;
  logic             mst_r_hs_q;
  ids_pkg::mst_ar_t mst_ar_cap_q;

  tb_clk_gen #(
    .PERIOD_NS  ( 8.0 ),
    .RST_CYCLES ( 2   )
  ) i_clk_gen (
    .clk_o    ( clk    ),
    .arst_n_o ( arst_n )
  );

  axi_id_serialize uut (
    .clk_i          ( clk          ),
    .arst_n_i       ( arst_n       ),
    .slv_ar_valid_i ( slv_ar_valid ),
    .slv_ar_i       ( slv_ar       ),
    .slv_ar_ready_o ( slv_ar_ready ),
    .slv_r_valid_o  ( slv_r_valid  ),
    .slv_r_o        ( slv_r        ),
    .slv_r_ready_i  ( slv_r_ready  ),
    .mst_ar_valid_o ( mst_ar_valid ),
    .mst_ar_o       ( mst_ar       ),
    .mst_ar_ready_i ( mst_ar_ready ),
    .mst_r_valid_i  ( mst_r_valid  ),
    .mst_r_i        ( mst_r        ),
    .mst_r_ready_o  ( mst_r_ready  )
  );

  // Galois form of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h8020_0003;
    end
    return s >> 1;
  endfunction

  // One LFSR step per random bit
  task automatic draw_bit(output logic b);
    lfsr_q = lfsr_next(lfsr_q);
    b      = lfsr_q[0];
  endtask

  // Master ID from slave ID by the offset rule
  function automatic int map_id(input logic [`IDS_SLV_ID_W-1:0] sid);
    return (int'(sid) + `IDS_ID_BASE_OFFSET) % `IDS_NUM_SLOTS;
  endfunction

  function automatic int find_open_burst(input logic [`IDS_SLV_ID_W-1:0] sid);
    for (int i = 0; i < exp_q.size(); i++) begin
      if (exp_q[i].id == sid) return i;
    end
    return -1;
  endfunction

  function automatic int find_mem_head(input int mid);
    for (int i = 0; i < mem_q.size(); i++) begin
      if (int'(mem_q[i].id) == mid) return i;
    end
    return -1;
  endfunction

  task automatic check_value(input string name, input logic [63:0] act,
                             input logic [63:0] exp);
    check_cnt++;
    if (act !== exp) begin
      error_cnt++;
      $display("[ERROR] t=%0t %s expected %0h actual %0h", $time, name, exp, act);
    end
  endtask

  // Scoreboard side of one slave R beat, owner known from its master ID
  task automatic check_r_beat(input ids_pkg::slv_r_t beat, input int mid);
    int pos;
    int sid;
    ids_pkg::slv_ar_t req;
    sid = int'(owner_sid[mid]);
    check_value("slv_r_o.id", beat.id, owner_sid[mid]);
    pos = find_open_burst(owner_sid[mid]);
    if (pos < 0) begin
      error_cnt++;
      $display("R beat at %0t on master ID %0d has no open burst", $time, mid);
    end else begin
      req = exp_q[pos];
      check_value("slv_r_o.data", beat.data, req.addr + 32'(sid_beat[sid]));
      check_value("slv_r_o.resp", beat.resp, ids_pkg::OKAY);
      check_value("slv_r_o.last", beat.last, sid_beat[sid] == int'(req.len));
      if (sid_beat[sid] == int'(req.len)) begin
        exp_q.delete(pos);
        sid_beat[sid] = 0;
        done_cnt++;
        in_flight[mid]--;
      end else begin
        sid_beat[sid]++;
      end
    end
  endtask

  // Master ARs leave in slave AR order through the single register
  task automatic check_mst_ar(input ids_pkg::mst_ar_t ar);
    int mid;
    ids_pkg::slv_ar_t req;
    mid = int'(ar.id);
    if (pend_q.size() == 0) begin
      error_cnt++;
      $display("Master AR at %0t on master ID %0d has no pending slave request", $time, mid);
    end else begin
      req = pend_q.pop_front();
      check_value("mst_ar_o.id", ar.id, map_id(req.id));
      check_value("mst_ar_o.addr", ar.addr, req.addr);
      check_value("mst_ar_o.len", ar.len, req.len);
      if (in_flight[mid] > 0 && owner_sid[mid] != req.id) begin
        error_cnt++;
        $display("Master ID %0d issued for slave ID %0h at %0t while slave ID %0h in flight",
                 mid, req.id, $time, owner_sid[mid]);
      end
      owner_sid[mid] = req.id;
      in_flight[mid]++;
      if (in_flight[mid] > `IDS_MAX_TXNS_PER_ID) begin
        error_cnt++;
        $display("Master ID %0d holds %0d bursts at %0t, above the limit",
                 mid, in_flight[mid], $time);
      end
    end
  endtask

  // Monitor, samples handshakes on the rising edge
  always @(posedge clk) begin
    slv_ar_hs_q  = slv_ar_valid && slv_ar_ready;
    mst_ar_hs_q  = mst_ar_valid && mst_ar_ready;
    mst_ar_cap_q = mst_ar;
    mst_r_hs_q   = mst_r_valid && mst_r_ready;
    if (slv_r_valid && slv_r_ready) begin
      check_r_beat(slv_r, int'(mst_r.id));
    end
    if (mst_ar_hs_q) begin
      check_mst_ar(mst_ar);
    end
    if (slv_ar_hs_q) begin
      pend_q.push_back(slv_ar);
      exp_q.push_back(slv_ar);
    end
  end

  // Driver and memory model, inputs change on the falling edge
  always @(negedge clk) begin
    logic             b0;
    logic             b1;
    int               mid;
    int               pos;
    int               start;
    ids_pkg::mst_ar_t head;
    if (run_en) begin
      // Slave AR payload held until taken
      if (slv_ar_hs_q) begin
        slv_ar_valid = 1'b0;
        case_idx++;
      end
      if (!slv_ar_valid && case_idx < n_cases) begin
        draw_bit(b0);
        draw_bit(b1);
        if (b0 || b1) begin
          slv_ar_valid = 1'b1;
          slv_ar       = case_mem[case_idx];
        end
      end
      // Ready high about three cycles in four
      draw_bit(b0);
      draw_bit(b1);
      mst_ar_ready = b0 || b1;
      if (mst_ar_hs_q) begin
        mem_q.push_back(mst_ar_cap_q);
      end
      if (mst_r_hs_q) begin
        mid         = int'(mst_r.id);
        mst_r_valid = 1'b0;
        if (mst_r.last) begin
          pos = find_mem_head(mid);
          if (pos >= 0) mem_q.delete(pos);
          mem_beat[mid] = 0;
        end else begin
          mem_beat[mid]++;
        end
      end
      // In order per master ID, random pick across IDs
      if (!mst_r_valid && mem_q.size() > 0) begin
        draw_bit(b0);
        if (b0) begin
          draw_bit(b0);
          draw_bit(b1);
          start = int'({b1, b0});
          mid   = -1;
          for (int k = 0; k < `IDS_NUM_SLOTS; k++) begin
            if (mid < 0 && find_mem_head((start + k) % `IDS_NUM_SLOTS) >= 0) begin
              mid = (start + k) % `IDS_NUM_SLOTS;
            end
          end
          head        = mem_q[find_mem_head(mid)];
          mst_r_valid = 1'b1;
          mst_r.id    = head.id;
          mst_r.data  = head.addr + 32'(mem_beat[mid]);
          mst_r.resp  = ids_pkg::OKAY;
          mst_r.last  = (mem_beat[mid] == int'(head.len));
        end
      end
      draw_bit(b0);
      draw_bit(b1);
      slv_r_ready = b0 || b1;
    end
  end

  // Cycle limit scaled to the case count and longest burst
  always @(posedge clk) begin
    cycle_cnt++;
    if (limit_cycles > 0 && cycle_cnt > limit_cycles) begin
      $display("Timeout after %0d cycles with %0d of %0d bursts done",
               cycle_cnt, done_cnt, n_cases);
      $display("Checks %0d, errors %0d, bursts done %0d of %0d",
               check_cnt, error_cnt, done_cnt, n_cases);
      $display("test failed");
      $finish;
    end
  end

  initial begin
    slv_ar_valid = 1'b0;
    slv_ar       = '0;
    slv_r_ready  = 1'b0;
    mst_ar_ready = 1'b0;
    mst_r_valid  = 1'b0;
    mst_r        = '0;
    slv_ar_hs_q  = 1'b0;
    mst_ar_hs_q  = 1'b0;
    mst_r_hs_q   = 1'b0;
    run_en       = 1'b0;
    lfsr_q       = 32'hcd03_5bc2;
    n_cases      = 0;
    case_idx     = 0;
    max_len      = 0;
    limit_cycles = 0;
    cycle_cnt    = 0;
    check_cnt    = 0;
    error_cnt    = 0;
    done_cnt     = 0;
    // All ones marks the end of the cases
    for (int i = 0; i < MAX_CASES; i++) begin
      case_mem[i] = '1;
    end
    $readmemh("sim/ids_cases.txt", case_mem);
    while (n_cases < MAX_CASES && case_mem[n_cases] !== {CASE_W{1'b1}}) begin
      if (int'(case_mem[n_cases][`IDS_LEN_W-1:0]) > max_len) begin
        max_len = int'(case_mem[n_cases][`IDS_LEN_W-1:0]);
      end
      n_cases++;
    end
    if (n_cases == 0) begin
      error_cnt++;
      $display("No cases read from sim/ids_cases.txt");
    end
    limit_cycles = n_cases * (max_len + 20);
    // Idle outputs right after reset
    wait (arst_n);
    @(negedge clk);
    check_value("mst_ar_valid_o", mst_ar_valid, 1'b0);
    check_value("slv_r_valid_o", slv_r_valid, 1'b0);
    run_en = 1'b1;
    wait (done_cnt == n_cases);
    repeat (4) @(negedge clk);
    check_value("pending master ARs", pend_q.size(), 0);
    check_value("open bursts", exp_q.size(), 0);
    check_value("mst_ar_valid_o", mst_ar_valid, 1'b0);
    $display("Checks %0d, errors %0d, bursts done %0d of %0d",
             check_cnt, error_cnt, done_cnt, n_cases);
    if (error_cnt == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// File: sim/tb_clk_gen.sv
// **********************************************************************
// Testbench clock and reset generator
// **********************************************************************

`timescale 1ns/1ps

module tb_clk_gen #(
  parameter real PERIOD_NS  = 8.0,
  parameter int  RST_CYCLES = 2
) (
  output logic clk_o,
  output logic arst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2.0) clk_o = ~clk_o;
  end

  // Reset spans full cycles and lifts on a falling edge
  initial begin
    arst_n_o = 1'b0;
    repeat (RST_CYCLES) @(negedge clk_o);
    arst_n_o = 1'b1;
  end

endmodule
